/* bench/execTrace.txt */
# name chain instr pc | writeEnable writeReg writeData redirect target exception (hex)
# chain 1 issues right after the previous line; exception 0 none 1 unknown 2 syscall 3 break 4 ovf
rst_read    0 00641021 00400000 1 02 00000000 0 00000000 0
wr_zero     0 24001234 00400004 1 00 00001234 0 00000000 0
rd_zero     1 00001821 00400008 1 03 00000000 0 00000000 0
ori_r1      0 3401F0F0 0040000C 1 01 0000F0F0 0 00000000 0
lui_r2      0 3C028000 00400010 1 02 80000000 0 00000000 0
addiu_r3    0 2403FFFF 00400014 1 03 FFFFFFFF 0 00000000 0
addu_r4     0 00222021 00400018 1 04 8000F0F0 0 00000000 0
subu_r5     0 00232823 0040001C 1 05 0000F0F1 0 00000000 0
and_r6      0 00833024 00400020 1 06 8000F0F0 0 00000000 0
or_r7       0 00223825 00400024 1 07 8000F0F0 0 00000000 0
xor_r8      0 00814026 00400028 1 08 80000000 0 00000000 0
nor_r9      0 00204827 0040002C 1 09 FFFF0F0F 0 00000000 0
sll_r10     0 00015100 00400030 1 0A 000F0F00 0 00000000 0
sra_r11     0 00025A03 00400034 1 0B FF800000 0 00000000 0
srl_r12     0 000267C2 00400038 1 0C 00000001 0 00000000 0
sllv_r13    1 01816804 0040003C 1 0D 0001E1E0 0 00000000 0
srav_r14    0 00A27007 00400040 1 0E FFFFC000 0 00000000 0
srlv_r15    0 01837806 00400044 1 0F 7FFFFFFF 0 00000000 0
slt_r16     0 0041802A 00400048 1 10 00000001 0 00000000 0
sltu_r17    0 0041882B 0040004C 1 11 00000000 0 00000000 0
slti_r18    0 28720000 00400050 1 12 00000001 0 00000000 0
sltiu_r19   0 2C33FFFF 00400054 1 13 00000001 0 00000000 0
andi_r20    0 30748001 00400058 1 14 00008001 0 00000000 0
xori_r21    0 3835FFFF 0040005C 1 15 00000F0F 0 00000000 0
chain_a     0 24050007 00400060 1 05 00000007 0 00000000 0
chain_b     1 00A52821 00400064 1 05 0000000E 0 00000000 0
chain_c     1 00A03021 00400068 1 06 0000000E 0 00000000 0
chain_d     1 00C53823 0040006C 1 07 00000000 0 00000000 0
beq_taken   0 10C50003 00400070 0 00 00000000 1 00400080 0
bne_not     0 14C50003 00400074 0 00 00000000 0 00000000 0
blez_taken  0 1860FFFE 00400078 0 00 00000000 1 00400074 0
bgtz_not    0 1C600004 0040007C 0 00 00000000 0 00000000 0
bltzal_tk   0 04700010 00400080 1 1F 00400088 1 004000C4 0
bgez_not    0 04410005 00400084 0 00 00000000 0 00000000 0
j_imm       0 08100040 00400088 0 00 00000000 1 00400100 0
jal_imm     0 0C100080 0040008C 1 1F 00400094 1 00400200 0
jr_r31      1 03E00008 00400090 0 00 00000000 1 00400094 0
jalr_r18    0 01409009 00400094 1 12 0040009C 1 000F0F00 0
add_ovf     0 00422820 00400098 0 00 00000000 0 00000000 4
addi_ovf    0 2046FFFF 0040009C 0 00 00000000 0 00000000 4
syscall     0 0000000C 004000A0 0 00 00000000 0 00000000 2
break       0 0000000D 004000A4 0 00 00000000 0 00000000 3
lw_unknown  0 8C050000 004000A8 0 00 00000000 0 00000000 1
after_exc   1 00A6B021 004000AC 1 16 0000001C 0 00000000 0

/* bench/tbMipsExecCore.sv */
`timescale 1ns/100ps
`include "mipsCore_defines.svh"

module tbMipsExecCore import mipsCore_pkg::*; ();

    logic      clk;
    logic      reset;
    logic      issueValid;
    issueReq_t issue;
    logic      retireValid;
    retire_t   retire;

    retire_t   expQ[$];
    string     nameQ[$];
    int        issueCycleQ[$];
    int        cycleCount = 0;
    word_t     rngState = 32'h2586;

    mipsExecCore i_dut (
        .clk(clk), .reset(reset),
        .issueValid(issueValid), .issue(issue),
        .retireValid(retireValid), .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    function automatic word_t nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    task automatic stopWithFailure(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkWord(input string test, input string field, input word_t exp,
                             input word_t act);
        if (act !== exp) begin
            stopWithFailure($sformatf("FAILED %s %s: expected %h, actual %h",
                                      test, field, exp, act));
        end
    endtask

    task automatic checkReg(input string test, input string field, input regIdx_t exp,
                            input regIdx_t act);
        if (act !== exp) begin
            stopWithFailure($sformatf("FAILED %s %s: expected r%0d, actual r%0d",
                                      test, field, exp, act));
        end
    endtask

    task automatic checkExc(input string test, input excCode_t exp, input excCode_t act);
        if (act !== exp) begin
            stopWithFailure($sformatf("FAILED %s exception: expected %s, actual %s",
                                      test, exp.name(), act.name()));
        end
    endtask

    task automatic checkBit(input string test, input string field, input logic exp,
                            input logic act);
        if (act !== exp) begin
            stopWithFailure($sformatf("FAILED %s %s: expected %b, actual %b",
                                      test, field, exp, act));
        end
    endtask

    task automatic compareRetire(input string test, input retire_t exp, input int issuedAt);
        if (cycleCount - issuedAt != 2) begin
            stopWithFailure($sformatf("FAILED %s latency: expected 2, actual %0d",
                                      test, cycleCount - issuedAt));
        end
        checkWord(test, "pc", exp.pc, retire.pc);
        checkBit(test, "writeEnable", exp.writeEnable, retire.writeEnable);
        if (exp.writeEnable) begin
            checkReg(test, "writeReg", exp.writeReg, retire.writeReg);
            checkWord(test, "writeData", exp.writeData, retire.writeData);
        end
        checkBit(test, "redirect", exp.redirect, retire.redirect);
        if (exp.redirect) begin
            checkWord(test, "target", exp.target, retire.target);  // Only meaningful when taken.
        end
        checkExc(test, exp.exception, retire.exception);
    endtask

    // One trace line, after its idle gap.
    task automatic issueOne(input string test, input logic chained, input word_t instr,
                            input retire_t exp);
        int gap;
        gap = chained ? 0 : int'(nextRandom() % 3);
        repeat (gap) begin
            @(posedge clk);
            #1;
            issueValid = 1'b0;
        end
        @(posedge clk);
        #1;
        issueValid  = 1'b1;
        issue.instr = instr;
        issue.pc    = exp.pc;
        expQ.push_back(exp);
        nameQ.push_back(test);
        issueCycleQ.push_back(cycleCount);
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (retireValid !== 1'b0 && retireValid !== 1'b1) begin
                stopWithFailure("retireValid is unknown after reset");
            end
            else if (retireValid && expQ.size() == 0) begin
                stopWithFailure("retire strobe seen with no instruction outstanding");
            end
            else if (retireValid) begin
                compareRetire(nameQ.pop_front(), expQ.pop_front(), issueCycleQ.pop_front());
            end
        end
    end

    initial begin
        int      fd;
        int      count;
        int      waitCount;
        string   line;
        string   test;
        word_t   chainV;
        word_t   instrV;
        word_t   pcV;
        word_t   weV;
        word_t   wregV;
        word_t   wdataV;
        word_t   redirV;
        word_t   targetV;
        word_t   excV;
        retire_t exp;

        reset      = 1'b1;
        issueValid = 1'b0;
        issue      = '0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        fd = $fopen("bench/execTrace.txt", "r");
        if (fd == 0) begin
            stopWithFailure("cannot open bench/execTrace.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                count = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", test, chainV, instrV,
                                pcV, weV, wregV, wdataV, redirV, targetV, excV);
                if (count != 10) begin
                    stopWithFailure($sformatf("malformed trace line: %s", line));
                end
                exp.pc          = pcV;
                exp.writeEnable = weV[0];
                exp.writeReg    = wregV[4:0];
                exp.writeData   = wdataV;
                exp.redirect    = redirV[0];
                exp.target      = targetV;
                exp.exception   = excCode_t'(excV[2:0]);
                // A jal links its return address into the link register.
                if (instrV[31:26] == 6'h03) begin
                    exp.writeEnable = 1'b1;
                    exp.writeReg    = `LINK_REG;
                    exp.writeData   = pcV + `LINK_OFFSET;
                end
                issueOne(test, chainV[0], instrV, exp);
            end
        end
        $fclose(fd);
        @(posedge clk);
        #1;
        issueValid = 1'b0;

        waitCount = 0;
        while (expQ.size() != 0 && waitCount < 50) begin
            @(posedge clk);
            waitCount++;
        end
        repeat (3) @(posedge clk);  // Catch stray strobes.
        if (expQ.size() != 0) begin
            stopWithFailure($sformatf("%0d instructions never retired", expQ.size()));
        end
        else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

/* common/mipsCore_defines.svh */
`ifndef MIPSCORE_DEFINES_SVH
`define MIPSCORE_DEFINES_SVH

// Offset from the PC of a linking instruction to its return address.
// It skips the instruction and its delay slot.
`define LINK_OFFSET 32'd8

// Return address register used by jal, bltzal and bgezal.
`define LINK_REG 5'd31

// Number of general purpose registers.
`define REG_COUNT 32

`endif

/* common/mipsCore_pkg.sv */
package mipsCore_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regIdx_t;
    typedef logic [4:0]  shamt_t;   // Shift amount field.

    typedef enum logic [3:0] {
        aluDisabled, aluAdd, aluSub,
        aluAnd, aluOr, aluXor, aluNor,
        aluShiftLeft, aluShiftRight, aluArithShiftRight,
        aluSlt, aluSltu
    } aluOp_t;

    typedef enum logic [2:0] {
        cmpEqual, cmpNotEqual,
        cmpLessEqualZero, cmpGreaterZero,
        cmpLessZero, cmpGreaterEqualZero
    } cmpOp_t;

    typedef enum logic [1:0] {
        jumpNone, jumpBranch, jumpImmediate, jumpRegister
    } jumpKind_t;

    typedef enum logic [1:0] {
        wbNone, wbAlu, wbLink
    } wbSel_t;

    typedef enum logic [2:0] {
        excNone, excUnknownInstr, excSyscall, excBreak, excOverflow
    } excCode_t;

    // Zero in every field decodes as a bubble.
    typedef struct packed {
        regIdx_t   readIdx1;
        regIdx_t   readIdx2;
        logic      readReq1;
        logic      readReq2;
        regIdx_t   destReg;
        wbSel_t    wbSel;
        aluOp_t    aluOp;
        logic      aluSrc;          // Second ALU operand is the immediate.
        logic      checkOverflow;
        word_t     immediate;
        shamt_t    shamt;
        cmpOp_t    cmpOp;
        jumpKind_t jumpKind;
        excCode_t  exception;
    } decodedCtrl_t;

    typedef struct packed {
        word_t instr;
        word_t pc;
    } issueReq_t;

    typedef struct packed {
        word_t    pc;
        logic     writeEnable;
        regIdx_t  writeReg;
        word_t    writeData;
        logic     redirect;
        word_t    target;
        excCode_t exception;
    } retire_t;

endpackage

/* decode/instrDecoder.sv */
`timescale 1ns/100ps
`include "mipsCore_defines.svh"

module instrDecoder import mipsCore_pkg::*; (
    input  word_t        instr,
    output decodedCtrl_t ctrl
);
    localparam logic [5:0] opSpecial = 6'b000000;
    localparam logic [5:0] opRegimm  = 6'b000001;
    localparam logic [5:0] opJ       = 6'b000010;
    localparam logic [5:0] opJal     = 6'b000011;
    localparam logic [5:0] opBeq     = 6'b000100;
    localparam logic [5:0] opBne     = 6'b000101;
    localparam logic [5:0] opBlez    = 6'b000110;
    localparam logic [5:0] opBgtz    = 6'b000111;
    localparam logic [5:0] opAddi    = 6'b001000;
    localparam logic [5:0] opAddiu   = 6'b001001;
    localparam logic [5:0] opSlti    = 6'b001010;
    localparam logic [5:0] opSltiu   = 6'b001011;
    localparam logic [5:0] opAndi    = 6'b001100;
    localparam logic [5:0] opOri     = 6'b001101;
    localparam logic [5:0] opXori    = 6'b001110;
    localparam logic [5:0] opLui     = 6'b001111;

    localparam logic [5:0] fnSll     = 6'b000000;
    localparam logic [5:0] fnSrl     = 6'b000010;
    localparam logic [5:0] fnSra     = 6'b000011;
    localparam logic [5:0] fnSllv    = 6'b000100;
    localparam logic [5:0] fnSrlv    = 6'b000110;
    localparam logic [5:0] fnSrav    = 6'b000111;
    localparam logic [5:0] fnJr      = 6'b001000;
    localparam logic [5:0] fnJalr    = 6'b001001;
    localparam logic [5:0] fnSyscall = 6'b001100;
    localparam logic [5:0] fnBreak   = 6'b001101;
    localparam logic [5:0] fnAdd     = 6'b100000;
    localparam logic [5:0] fnAddu    = 6'b100001;
    localparam logic [5:0] fnSub     = 6'b100010;
    localparam logic [5:0] fnSubu    = 6'b100011;
    localparam logic [5:0] fnAnd     = 6'b100100;
    localparam logic [5:0] fnOr      = 6'b100101;
    localparam logic [5:0] fnXor     = 6'b100110;
    localparam logic [5:0] fnNor     = 6'b100111;
    localparam logic [5:0] fnSlt     = 6'b101010;
    localparam logic [5:0] fnSltu    = 6'b101011;

    localparam regIdx_t rtBltz   = 5'b00000;
    localparam regIdx_t rtBgez   = 5'b00001;
    localparam regIdx_t rtBltzal = 5'b10000;
    localparam regIdx_t rtBgezal = 5'b10001;

    logic [5:0] opcode;
    logic [5:0] funct;
    regIdx_t    rs;
    regIdx_t    rt;
    regIdx_t    rd;
    word_t      signExtImm;
    word_t      zeroExtImm;
    word_t      upperImm;
    word_t      jumpIndex;

    assign opcode     = instr[31:26];
    assign funct      = instr[5:0];
    assign rs         = instr[25:21];
    assign rt         = instr[20:16];
    assign rd         = instr[15:11];
    assign signExtImm = {{16{instr[15]}}, instr[15:0]};
    assign zeroExtImm = {16'b0, instr[15:0]};
    assign upperImm   = {instr[15:0], 16'b0};
    assign jumpIndex  = {6'b0, instr[25:0]};

    always_comb begin
        ctrl = '0;
        case (opcode)
            opSpecial: begin
                // Three-register defaults; the shift and jump forms override them.
                ctrl.readIdx1 = rs;
                ctrl.readIdx2 = rt;
                ctrl.readReq1 = 1'b1;
                ctrl.readReq2 = 1'b1;
                ctrl.destReg  = rd;
                ctrl.wbSel    = wbAlu;
                case (funct)
                    fnAdd: begin
                        ctrl.aluOp         = aluAdd;
                        ctrl.checkOverflow = 1'b1;
                    end
                    fnAddu: ctrl.aluOp = aluAdd;
                    fnSub: begin
                        ctrl.aluOp         = aluSub;
                        ctrl.checkOverflow = 1'b1;
                    end
                    fnSubu: ctrl.aluOp = aluSub;
                    fnAnd:  ctrl.aluOp = aluAnd;
                    fnOr:   ctrl.aluOp = aluOr;
                    fnXor:  ctrl.aluOp = aluXor;
                    fnNor:  ctrl.aluOp = aluNor;
                    fnSlt:  ctrl.aluOp = aluSlt;
                    fnSltu: ctrl.aluOp = aluSltu;
                    fnSll, fnSrl, fnSra: begin
                        ctrl.readIdx1 = rt;
                        ctrl.readIdx2 = '0;
                        ctrl.readReq2 = 1'b0;
                        ctrl.aluSrc   = 1'b1;   // Zero immediate, amount from shamt.
                        ctrl.shamt    = instr[10:6];
                        ctrl.aluOp    = (funct == fnSll) ? aluShiftLeft :
                                        (funct == fnSrl) ? aluShiftRight : aluArithShiftRight;
                    end
                    fnSllv, fnSrlv, fnSrav: begin
                        ctrl.readIdx1 = rt;
                        ctrl.readIdx2 = rs;     // Amount travels on b.
                        ctrl.aluOp    = (funct == fnSllv) ? aluShiftLeft :
                                        (funct == fnSrlv) ? aluShiftRight : aluArithShiftRight;
                    end
                    fnJr, fnJalr: begin
                        ctrl.readIdx2 = '0;
                        ctrl.readReq2 = 1'b0;
                        ctrl.jumpKind = jumpRegister;
                        ctrl.wbSel    = (funct == fnJalr) ? wbLink : wbNone;
                        ctrl.destReg  = (funct == fnJalr) ? rd : '0;
                    end
                    fnSyscall: begin
                        ctrl           = '0;
                        ctrl.exception = excSyscall;
                    end
                    fnBreak: begin
                        ctrl           = '0;
                        ctrl.exception = excBreak;
                    end
                    default: begin
                        ctrl           = '0;    // Multiply, divide and the rest.
                        ctrl.exception = excUnknownInstr;
                    end
                endcase
            end
            opRegimm: begin
                ctrl.readIdx1  = rs;
                ctrl.readReq1  = 1'b1;
                ctrl.jumpKind  = jumpBranch;
                ctrl.immediate = signExtImm;
                ctrl.cmpOp     = rt[0] ? cmpGreaterEqualZero : cmpLessZero;
                if (rt == rtBltzal || rt == rtBgezal) begin
                    ctrl.wbSel   = wbLink;  // Links whether or not taken.
                    ctrl.destReg = regIdx_t'(`LINK_REG);
                end
                else if (rt != rtBltz && rt != rtBgez) begin
                    ctrl           = '0;
                    ctrl.exception = excUnknownInstr;
                end
            end
            opBeq, opBne, opBlez, opBgtz: begin
                ctrl.readIdx1  = rs;
                ctrl.readReq1  = 1'b1;
                ctrl.jumpKind  = jumpBranch;
                ctrl.immediate = signExtImm;
                case (opcode)
                    opBeq:   ctrl.cmpOp = cmpEqual;
                    opBne:   ctrl.cmpOp = cmpNotEqual;
                    opBlez:  ctrl.cmpOp = cmpLessEqualZero;
                    default: ctrl.cmpOp = cmpGreaterZero;
                endcase
                if (opcode == opBeq || opcode == opBne) begin
                    ctrl.readIdx2 = rt;
                    ctrl.readReq2 = 1'b1;
                end
            end
            opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori: begin
                ctrl.readIdx1      = rs;
                ctrl.readReq1      = 1'b1;
                ctrl.destReg       = rt;
                ctrl.wbSel         = wbAlu;
                ctrl.aluSrc        = 1'b1;
                ctrl.immediate     = (opcode >= opAndi) ? zeroExtImm : signExtImm;
                ctrl.checkOverflow = (opcode == opAddi);
                case (opcode)
                    opAddi, opAddiu: ctrl.aluOp = aluAdd;
                    opSlti:          ctrl.aluOp = aluSlt;
                    opSltiu:         ctrl.aluOp = aluSltu;
                    opAndi:          ctrl.aluOp = aluAnd;
                    opOri:           ctrl.aluOp = aluOr;
                    default:         ctrl.aluOp = aluXor;
                endcase
            end
            opLui: begin
                ctrl.destReg   = rt;    // Register zero or'ed with the upper half.
                ctrl.wbSel     = wbAlu;
                ctrl.aluSrc    = 1'b1;
                ctrl.aluOp     = aluOr;
                ctrl.immediate = upperImm;
            end
            opJ, opJal: begin
                ctrl.jumpKind  = jumpImmediate;
                ctrl.immediate = jumpIndex;
                if (opcode == opJal) begin
                    ctrl.wbSel   = wbLink;
                    ctrl.destReg = regIdx_t'(`LINK_REG);
                end
            end
            default: ctrl.exception = excUnknownInstr;  // Loads, stores, coprocessors.
        endcase
    end

endmodule

/* rtl/aluUnit.sv */
`timescale 1ns/100ps

module aluUnit import mipsCore_pkg::*; (
    input  aluOp_t op,
    input  word_t  a,
    input  word_t  b,
    input  shamt_t shamt,
    input  logic   checkOverflow,
    output word_t  result,
    output logic   overflow
);
    word_t  sum;
    word_t  diff;
    shamt_t shiftAmount;
    logic   addOverflow;
    logic   subOverflow;

    assign sum  = a + b;
    assign diff = a - b;

    // Fixed shifts arrive with b at zero, variable shifts with shamt at zero.
    assign shiftAmount = (shamt != '0) ? shamt : b[4:0];

    assign addOverflow = (a[31] == b[31]) && (sum[31] != a[31]);
    assign subOverflow = (a[31] != b[31]) && (diff[31] != a[31]);

    always_comb begin
        case (op)
            aluAdd:             result = sum;
            aluSub:             result = diff;
            aluAnd:             result = a & b;
            aluOr:              result = a | b;
            aluXor:             result = a ^ b;
            aluNor:             result = ~(a | b);
            aluShiftLeft:       result = a << shiftAmount;
            aluShiftRight:      result = a >> shiftAmount;
            aluArithShiftRight: result = $signed(a) >>> shiftAmount;
            aluSlt:             result = {31'b0, $signed(a) < $signed(b)};
            aluSltu:            result = {31'b0, a < b};
            default:            result = '0;
        endcase
    end

    always_comb begin
        overflow = 1'b0;
        if (checkOverflow) begin
            if (op == aluAdd) begin
                overflow = addOverflow;
            end
            else if (op == aluSub) begin
                overflow = subOverflow;
            end
        end
    end

endmodule

/* rtl/branchUnit.sv */
`timescale 1ns/100ps
`include "mipsCore_defines.svh"

module branchUnit import mipsCore_pkg::*; (
    input  jumpKind_t kind,
    input  cmpOp_t    cmp,
    input  word_t     a,
    input  word_t     b,
    input  word_t     pc,
    input  word_t     imm,
    output logic      redirect,
    output word_t     target,
    output word_t     linkValue
);
    word_t pcPlus4;
    logic  taken;

    assign pcPlus4   = pc + 32'd4;
    assign linkValue = pc + `LINK_OFFSET;

    always_comb begin
        case (cmp)
            cmpEqual:            taken = (a == b);
            cmpNotEqual:         taken = (a != b);
            cmpLessEqualZero:    taken = a[31] || (a == '0);
            cmpGreaterZero:      taken = !a[31] && (a != '0);
            cmpLessZero:         taken = a[31];
            cmpGreaterEqualZero: taken = !a[31];
            default:             taken = 1'b0;
        endcase
    end

    always_comb begin
        redirect = 1'b1;
        case (kind)
            jumpBranch: begin
                redirect = taken;
                target   = pcPlus4 + {imm[29:0], 2'b00};
            end
            jumpImmediate: target = {pcPlus4[31:28], imm[25:0], 2'b00};
            jumpRegister:  target = a;
            default: begin
                redirect = 1'b0;
                target   = pcPlus4;     // Fall through.
            end
        endcase
    end

endmodule

/* rtl/mipsExecCore.sv */
`timescale 1ns/100ps

module mipsExecCore import mipsCore_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      issueValid,
    input  issueReq_t issue,
    output logic      retireValid,
    output retire_t   retire
);
    decodedCtrl_t decCtrl;
    word_t        rfData1;
    word_t        rfData2;
    word_t        opA;
    word_t        opB;

    logic         exValid;
    decodedCtrl_t exCtrl;
    word_t        exPc;
    word_t        exOpA;
    word_t        exOpB;

    word_t        aluB;
    word_t        aluResult;
    logic         aluOverflow;
    logic         brRedirect;
    word_t        brTarget;
    word_t        linkValue;
    excCode_t     exException;
    word_t        exWbData;
    logic         exWrites;
    logic         bypassHit;
    retire_t      retireNext;

    instrDecoder u_decoder (.instr(issue.instr), .ctrl(decCtrl));

    regFile u_regFile (
        .clk(clk), .reset(reset),
        .readIdx1(decCtrl.readIdx1), .readIdx2(decCtrl.readIdx2),
        .readData1(rfData1), .readData2(rfData2),
        .writeEnable(exWrites), .writeIdx(exCtrl.destReg), .writeData(exWbData)
    );

    // Only the execute stage can be newer than the file.
    assign bypassHit = exWrites && (exCtrl.destReg != '0);
    assign opA = (bypassHit && decCtrl.readReq1 && decCtrl.readIdx1 == exCtrl.destReg) ?
                 exWbData : rfData1;
    assign opB = (bypassHit && decCtrl.readReq2 && decCtrl.readIdx2 == exCtrl.destReg) ?
                 exWbData : rfData2;

    always_ff @(posedge clk) begin
        if (reset) begin
            exValid <= 1'b0;
        end
        else begin
            exValid <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        if (issueValid) begin
            exCtrl <= decCtrl;
            exPc   <= issue.pc;
            exOpA  <= opA;
            exOpB  <= opB;
        end
    end

    assign aluB = exCtrl.aluSrc ? exCtrl.immediate : exOpB;

    aluUnit u_alu (
        .op(exCtrl.aluOp), .a(exOpA), .b(aluB), .shamt(exCtrl.shamt),
        .checkOverflow(exCtrl.checkOverflow), .result(aluResult), .overflow(aluOverflow)
    );

    branchUnit u_branch (
        .kind(exCtrl.jumpKind), .cmp(exCtrl.cmpOp), .a(exOpA), .b(exOpB),
        .pc(exPc), .imm(exCtrl.immediate),
        .redirect(brRedirect), .target(brTarget), .linkValue(linkValue)
    );

    // Decoder exceptions take precedence over overflow.
    assign exException = (exCtrl.exception != excNone) ? exCtrl.exception :
                         aluOverflow ? excOverflow : excNone;
    assign exWbData = (exCtrl.wbSel == wbLink) ? linkValue : aluResult;
    assign exWrites = exValid && (exCtrl.wbSel != wbNone) && (exException == excNone);

    always_comb begin
        retireNext.pc          = exPc;
        retireNext.writeEnable = exWrites;
        retireNext.writeReg    = exCtrl.destReg;
        retireNext.writeData   = exWbData;
        retireNext.redirect    = exValid && brRedirect;
        retireNext.target      = brTarget;
        retireNext.exception   = exException;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retireValid        <= 1'b0;
            retire.writeEnable <= 1'b0;
            retire.redirect    <= 1'b0;
        end
        else begin
            retireValid <= exValid;
            retire      <= retireNext;
        end
    end

endmodule

/* rtl/regFile.sv */
`timescale 1ns/100ps
`include "mipsCore_defines.svh"

module regFile import mipsCore_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  regIdx_t readIdx1,
    input  regIdx_t readIdx2,
    output word_t   readData1,
    output word_t   readData2,
    input  logic    writeEnable,
    input  regIdx_t writeIdx,
    input  word_t   writeData
);
    word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end
        else if (writeEnable && writeIdx != '0) begin
            regs[writeIdx] <= writeData;
        end
    end

    // Register zero is hardwired.
    assign readData1 = (readIdx1 == '0) ? '0 : regs[readIdx1];
    assign readData2 = (readIdx2 == '0) ? '0 : regs[readIdx2];

endmodule

/* sim.f */
+incdir+common
common/mipsCore_pkg.sv
decode/instrDecoder.sv
rtl/regFile.sv
rtl/aluUnit.sv
rtl/branchUnit.sv
rtl/mipsExecCore.sv
bench/tbMipsExecCore.sv
